/* filelist.f */
hdl/icache_pkg.sv
hdl/icache_flush_counter.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_ctrl_fsm.sv
hdl/icache_top.sv
verif/icache_assertions.sv
verif/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module icache_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vicache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see $LOG"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verif/icache_tb.sv */
// cache testbench, applies a fetch table with a memory responder and a reference model
`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  localparam int NUM_SETS   = 1 << INDEX_WIDTH;
  localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  flush;    // sweep before this fetch
    logic [3:0]            stall;    // extra cycles with r_ready_i low
    logic                  exp_hit;
  } stim_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [ADDR_WIDTH-1:0] ar_addr_i;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [DATA_WIDTH-1:0] r_data_o;
  logic                  mem_ar_valid_o;
  logic                  mem_ar_ready_i;
  logic [ADDR_WIDTH-1:0] mem_ar_addr_o;
  logic                  mem_r_valid_i;
  logic                  mem_r_ready_o;
  logic [DATA_WIDTH-1:0] mem_r_data_i;
  logic                  flush_i;

  stim_t                 stim_q[$];
  int                    errors = 0;
  int                    mem_req_count = 0;  // refill requests seen by the responder
  logic [ADDR_WIDTH-1:0] last_req_addr;
  logic [TAG_WIDTH-1:0]  model_tag   [NUM_SETS][NUM_WAYS];
  logic                  model_valid [NUM_SETS][NUM_WAYS];
  logic [WAY_WIDTH-1:0]  model_ptr   [NUM_SETS];

  icache_top #(
    .INDEX_WIDTH(INDEX_WIDTH), .NUM_WAYS(NUM_WAYS), .WAY_WIDTH(WAY_WIDTH), .TAG_WIDTH(TAG_WIDTH)
  ) dut (.*);

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    stop_with_failure();
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // memory contents are the word address mixed with fixed constants
  function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] a);
    return {a ^ 32'h5a5a_c3c3, {a[15:0], a[31:16]} ^ 32'h0f1e_2d3c};
  endfunction

  function automatic logic predict_hit(input logic [ADDR_WIDTH-1:0] addr);
    logic [INDEX_WIDTH-1:0] idx;
    logic                   found;
    idx   = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    found = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (model_valid[idx][w] && (model_tag[idx][w] == addr[ADDR_WIDTH-1 -: TAG_WIDTH])) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // round robin victim, pointer steps on every refill of the set
  task automatic record_refill(input logic [ADDR_WIDTH-1:0] addr);
    logic [INDEX_WIDTH-1:0] idx;
    idx = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    model_tag[idx][model_ptr[idx]]   = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    model_valid[idx][model_ptr[idx]] = 1'b1;
    model_ptr[idx]                   = model_ptr[idx] + 1'b1;
  endtask

  task automatic check_pointers();
    for (int s = 0; s < NUM_SETS; s++) begin
      check_value(64'(dut.u_tags.ptr_q[s]), 64'(model_ptr[s]),
                  $sformatf("victim pointer of set %0d", s));
    end
  endtask

  function automatic void add_row(input logic [ADDR_WIDTH-1:0] addr, input logic flush,
                                  input int stall, input logic exp_hit);
    stim_q.push_back(stim_t'{addr, flush, 4'(stall), exp_hit});
  endfunction

  task automatic run_flush();
    int low_cycles;
    @(posedge clk);
    #2;
    flush_i = 1'b1;
    #1;
    check_value(64'(ar_ready_o), 64'(0), "ar_ready_o in the flush strobe cycle");
    @(posedge clk);
    #2;
    flush_i = 1'b0;
    #1;
    low_cycles = 1;  // strobe cycle
    while (!ar_ready_o) begin
      @(posedge clk);
      #3;
      low_cycles++;
      if (low_cycles > WAIT_LIMIT) stop_on_timeout("end of the flush sweep");
    end
    // strobe cycle plus one cycle per set
    check_value(64'(low_cycles), 64'(NUM_SETS + 1), "cycles with ar_ready_o low for a flush");
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) model_valid[s][w] = 1'b0;
    end
    check_pointers();
  endtask

  task automatic run_fetch(input logic [ADDR_WIDTH-1:0] addr, input int stall,
                           input logic exp_hit);
    logic [ADDR_WIDTH-1:0] aligned;
    logic [DATA_WIDTH-1:0] held_data;
    logic                  predicted;
    int                    reqs_before;
    int                    waited;
    aligned                    = addr;
    aligned[OFFSET_WIDTH-1:0]  = '0;
    predicted                  = predict_hit(addr);
    check_value(64'(predicted), 64'(exp_hit), "table hit flag against the model");
    reqs_before = mem_req_count;
    @(posedge clk);
    #2;
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    #1;
    waited = 0;
    while (!ar_ready_o) begin
      @(posedge clk);
      #3;
      waited++;
      if (waited > WAIT_LIMIT) stop_on_timeout("ar_ready_o");
    end
    @(posedge clk);  // accepting edge
    #2;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    #1;
    check_value(64'(ar_ready_o), 64'(0), "ar_ready_o after acceptance");
    waited = 0;
    while (!r_valid_o) begin
      @(posedge clk);
      #3;
      waited++;
      if (waited > WAIT_LIMIT) stop_on_timeout("r_valid_o");
    end
    if (predicted) check_value(64'(waited), 64'(2), "edges from acceptance to r_valid_o");
    check_value(64'(mem_req_count - reqs_before), 64'(predicted ? 0 : 1), "memory requests");
    check_value(64'(mem_req_count == reqs_before), 64'(exp_hit), "observed hit flag");
    if (!predicted) check_value(64'(last_req_addr), 64'(aligned), "refill request address");
    check_value(r_data_o, mem_word(aligned), "returned word");
    if (!predicted) record_refill(addr);
    held_data = r_data_o;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #3;
      check_value(64'(r_valid_o), 64'(1), "r_valid_o under back-pressure");
      check_value(r_data_o, held_data, "r_data_o under back-pressure");
      check_value(64'(ar_ready_o), 64'(0), "ar_ready_o under back-pressure");
    end
    @(posedge clk);
    #2;
    r_ready_i = 1'b1;
    @(posedge clk);  // response transfer edge
    #2;
    r_ready_i = 1'b0;
    #1;
    check_value(64'(r_valid_o), 64'(0), "r_valid_o after the response");
    check_value(64'(ar_ready_o), 64'(1), "ar_ready_o after the response");
  endtask

  initial begin : mem_responder
    int unsigned           delay;
    int                    waited;
    logic [ADDR_WIDTH-1:0] req_addr;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    forever begin
      @(posedge clk);
      #3;
      if (mem_ar_valid_o && !rst) begin
        req_addr      = mem_ar_addr_o;
        last_req_addr = req_addr;
        mem_req_count++;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        mem_ar_ready_i = 1'b1;
        @(posedge clk);  // request transfer edge
        #2;
        mem_ar_ready_i = 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        mem_r_valid_i = 1'b1;
        mem_r_data_i  = mem_word(req_addr);
        #1;
        waited = 0;
        while (!mem_r_ready_o) begin
          @(posedge clk);
          #3;
          waited++;
          if (waited > WAIT_LIMIT) stop_on_timeout("mem_r_ready_o");
        end
        @(posedge clk);  // refill data transfer edge
        #2;
        mem_r_valid_i = 1'b0;
      end
    end
  end

  initial begin : main
    rst        = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    flush_i    = 1'b0;
    void'($urandom(32'h6b0e));
    for (int s = 0; s < NUM_SETS; s++) begin
      model_ptr[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    // set 5 takes tags 1, 2 and 3, set 8 takes one line
    add_row(32'h0000_1028, 1'b0, 0, 1'b0);
    add_row(32'h0000_102c, 1'b0, 0, 1'b1);  // same word, other offset
    add_row(32'h0000_2028, 1'b0, 2, 1'b0);
    add_row(32'h0000_3028, 1'b0, 0, 1'b0);  // evicts tag 1
    add_row(32'h0000_1028, 1'b0, 0, 1'b0);  // evicts tag 2
    add_row(32'h0000_3028, 1'b0, 0, 1'b1);
    add_row(32'h0000_2028, 1'b0, 0, 1'b0);  // evicts tag 3
    add_row(32'h0000_0440, 1'b0, 5, 1'b0);
    add_row(32'h0000_0444, 1'b0, 3, 1'b1);
    add_row(32'h0000_1028, 1'b1, 0, 1'b0);  // flush first
    add_row(32'h0000_0440, 1'b0, 0, 1'b0);
    add_row(32'h0000_2028, 1'b0, 1, 1'b0);
    add_row(32'h0000_1028, 1'b0, 0, 1'b1);
    add_row(32'h0000_3028, 1'b0, 0, 1'b0);
    add_row(32'h0000_1028, 1'b0, 4, 1'b0);
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    #1;
    check_value(64'(ar_ready_o), 64'(1), "ar_ready_o after reset");
    check_value(64'(r_valid_o), 64'(0), "r_valid_o after reset");
    check_value(64'(mem_ar_valid_o), 64'(0), "mem_ar_valid_o after reset");
    check_value(64'(mem_r_ready_o), 64'(0), "mem_r_ready_o after reset");
    check_pointers();
    foreach (stim_q[i]) begin
      if (stim_q[i].flush) run_flush();
      run_fetch(stim_q[i].addr, int'(stim_q[i].stall), stim_q[i].exp_hit);
    end
    if (errors == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

/* verif/icache_assertions.sv */
// channel protocol and controller state checks, bound into the cache top level
`timescale 1ns/100ps

module icache_assertions (
  input logic                              clk,
  input logic                              rst,
  input logic                              ar_valid_i,
  input logic                              ar_ready_o,
  input logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr_i,
  input logic                              r_valid_o,
  input logic                              r_ready_i,
  input logic [icache_pkg::DATA_WIDTH-1:0] r_data_o,
  input logic                              mem_ar_valid_o,
  input logic                              mem_ar_ready_i,
  input logic [icache_pkg::ADDR_WIDTH-1:0] mem_ar_addr_o,
  input logic                              mem_r_valid_i,
  input logic                              mem_r_ready_o,
  input logic [icache_pkg::DATA_WIDTH-1:0] mem_r_data_i,
  input icache_pkg::cache_state_e          state_i
);
  import icache_pkg::*;

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_addr_i))
    else $error("fetch address dropped or changed before its transfer");

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else $error("returned word dropped or changed before its transfer");

  a_mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else $error("refill request dropped or changed before its transfer");

  a_mem_r_hold: assert property (@(posedge clk) disable iff (rst)
    mem_r_valid_i && !mem_r_ready_o |=> mem_r_valid_i && $stable(mem_r_data_i))
    else $error("refill data dropped or changed before its transfer");

  // only the idle state may take a new fetch
  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    (state_i != S_IDLE) |-> !ar_ready_o)
    else $error("ar_ready_o high outside the idle state");

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state_i inside {S_IDLE, S_HIT, S_AR, S_R, S_FLUSH})
    else $error("controller state register holds an unused encoding");

endmodule

bind icache_top icache_assertions u_assertions (
  .clk, .rst, .ar_valid_i, .ar_ready_o, .ar_addr_i, .r_valid_o, .r_ready_i, .r_data_o,
  .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o, .mem_r_valid_i, .mem_r_ready_o,
  .mem_r_data_i, .state_i(u_ctrl.state_q)
);

/* hdl/icache_top.sv */
// instruction cache top level, fetch channels upstream and refill channels to memory
`timescale 1ns/100ps

module icache_top #(
  parameter int INDEX_WIDTH = icache_pkg::INDEX_WIDTH,
  parameter int NUM_WAYS    = icache_pkg::NUM_WAYS,
  parameter int WAY_WIDTH   = icache_pkg::WAY_WIDTH,
  parameter int TAG_WIDTH   = icache_pkg::TAG_WIDTH
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [icache_pkg::DATA_WIDTH-1:0] r_data_o,
  output logic                              mem_ar_valid_o,
  input  logic                              mem_ar_ready_i,
  output logic [icache_pkg::ADDR_WIDTH-1:0] mem_ar_addr_o,
  input  logic                              mem_r_valid_i,
  output logic                              mem_r_ready_o,
  input  logic [icache_pkg::DATA_WIDTH-1:0] mem_r_data_i,
  input  logic                              flush_i
);
  import icache_pkg::*;

  logic [ADDR_WIDTH-1:0]  req_addr_q;   // aligned address of the fetch in flight
  logic [INDEX_WIDTH-1:0] data_index;
  logic                   hit;
  logic [WAY_WIDTH-1:0]   hit_way;
  logic [WAY_WIDTH-1:0]   victim_way;
  logic [WAY_WIDTH-1:0]   sel_way;
  logic                   tag_alloc;
  logic                   valid_set;
  logic                   rd_en;
  logic                   wr_en;
  logic                   flush_start;
  logic                   flush_done;
  logic [INDEX_WIDTH-1:0] flush_index;
  logic                   flush_active_q;

  always_ff @(posedge clk) begin
    if (ar_valid_i && ar_ready_o) begin
      req_addr_q <= addr_align(ar_addr_i);
    end
  end

  // tag store clears valid bits only while the sweep runs
  always_ff @(posedge clk) begin
    if (rst) begin
      flush_active_q <= 1'b0;
    end else if (flush_start) begin
      flush_active_q <= 1'b1;
    end else if (flush_done) begin
      flush_active_q <= 1'b0;
    end
  end

  assign mem_ar_addr_o = req_addr_q;
  // refill writes the latched set, hit reads the live lookup set
  assign data_index = wr_en ? req_addr_q[INDEX_LSB +: INDEX_WIDTH]
                            : ar_addr_i[INDEX_LSB +: INDEX_WIDTH];

  icache_ctrl_fsm #(.WAY_WIDTH(WAY_WIDTH)) u_ctrl (
    .clk, .rst, .ar_valid_i, .ar_ready_o, .r_valid_o, .r_ready_i,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_r_valid_i, .mem_r_ready_o, .flush_i,
    .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
    .tag_alloc_o(tag_alloc), .valid_set_o(valid_set), .rd_en_o(rd_en), .wr_en_o(wr_en),
    .sel_way_o(sel_way), .flush_start_o(flush_start), .flush_done_i(flush_done)
  );

  icache_flush_counter #(.INDEX_WIDTH(INDEX_WIDTH)) u_flush_cnt (
    .clk, .rst, .start_i(flush_start), .index_o(flush_index), .done_o(flush_done)
  );

  icache_tag_store #(
    .INDEX_WIDTH(INDEX_WIDTH), .NUM_WAYS(NUM_WAYS),
    .WAY_WIDTH(WAY_WIDTH), .TAG_WIDTH(TAG_WIDTH)
  ) u_tags (
    .clk, .rst, .lookup_addr_i(ar_addr_i),
    .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
    .alloc_i(tag_alloc), .alloc_way_i(sel_way), .valid_set_i(valid_set),
    .flush_active_i(flush_active_q), .flush_index_i(flush_index)
  );

  icache_data_store #(
    .INDEX_WIDTH(INDEX_WIDTH), .NUM_WAYS(NUM_WAYS), .WAY_WIDTH(WAY_WIDTH)
  ) u_data (
    .clk, .rd_en_i(rd_en), .wr_en_i(wr_en), .index_i(data_index), .way_i(sel_way),
    .wr_data_i(mem_r_data_i), .rd_data_o(r_data_o)
  );

endmodule

/* hdl/icache_ctrl_fsm.sv */
// cache controller FSM, sequences lookup, refill, response and flush for the stores
`timescale 1ns/100ps

module icache_ctrl_fsm #(
  parameter int WAY_WIDTH = icache_pkg::WAY_WIDTH
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output logic                 mem_ar_valid_o,
  input  logic                 mem_ar_ready_i,
  input  logic                 mem_r_valid_i,
  output logic                 mem_r_ready_o,
  input  logic                 flush_i,
  input  logic                 hit_i,
  input  logic [WAY_WIDTH-1:0] hit_way_i,
  input  logic [WAY_WIDTH-1:0] victim_way_i,
  output logic                 tag_alloc_o,
  output logic                 valid_set_o,
  output logic                 rd_en_o,
  output logic                 wr_en_o,
  output logic [WAY_WIDTH-1:0] sel_way_o,
  output logic                 flush_start_o,
  input  logic                 flush_done_i
);
  import icache_pkg::*;

  cache_state_e         state_q;
  cache_state_e         state_d;
  logic [WAY_WIDTH-1:0] way_q;       // way of the request in flight
  logic                 hit_wait_q;  // extra cycle after a hit read
  logic                 accept;
  logic                 r_xfer;
  logic                 mem_ar_xfer;
  logic                 mem_r_xfer;

  assign ar_ready_o  = (state_q == S_IDLE) && !flush_i;  // flush wins over a fetch
  assign accept      = ar_valid_i && ar_ready_o;
  assign r_xfer      = r_valid_o && r_ready_i;
  assign mem_ar_xfer = mem_ar_valid_o && mem_ar_ready_i;
  assign mem_r_xfer  = mem_r_ready_o && mem_r_valid_i;

  assign flush_start_o = (state_q == S_IDLE) && flush_i;
  assign rd_en_o       = accept && hit_i;     // data read at the accepting edge
  assign tag_alloc_o   = accept && !hit_i;    // victim claimed at the accepting edge
  assign wr_en_o       = mem_r_xfer;          // ready only raised in S_R
  assign valid_set_o   = mem_r_xfer;

  // lookup picks the way live, later phases reuse the latched one
  assign sel_way_o = (state_q == S_IDLE) ? (hit_i ? hit_way_i : victim_way_i) : way_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (flush_i) begin
          state_d = S_FLUSH;
        end else if (ar_valid_i) begin
          state_d = hit_i ? S_HIT : S_AR;
        end
      end
      S_HIT:   if (r_xfer) state_d = S_IDLE;
      S_AR:    if (mem_ar_xfer) state_d = S_R;
      S_R:     if (mem_r_xfer) state_d = S_HIT;  // response shares the hit state
      S_FLUSH: if (flush_done_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= S_IDLE;
      way_q          <= '0;
      hit_wait_q     <= 1'b0;
      r_valid_o      <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
    end else begin
      state_q    <= state_d;
      hit_wait_q <= rd_en_o;
      if (accept) begin
        way_q <= sel_way_o;
      end

      if (tag_alloc_o) begin
        mem_ar_valid_o <= 1'b1;
      end else if (mem_ar_xfer) begin
        mem_ar_valid_o <= 1'b0;
      end

      if (mem_ar_xfer) begin
        mem_r_ready_o <= 1'b1;
      end else if (mem_r_xfer) begin
        mem_r_ready_o <= 1'b0;
      end

      // refill word is forwarded, so valid follows the data edge directly
      if (r_xfer) begin
        r_valid_o <= 1'b0;
      end else if (mem_r_xfer) begin
        r_valid_o <= 1'b1;
      end else if ((state_q == S_HIT) && !hit_wait_q) begin
        r_valid_o <= 1'b1;
      end
    end
  end

endmodule

/* hdl/icache_data_store.sv */
// per-way word arrays with registered read, refill writes forward to the read port
`timescale 1ns/100ps

module icache_data_store #(
  parameter int INDEX_WIDTH = icache_pkg::INDEX_WIDTH,
  parameter int NUM_WAYS    = icache_pkg::NUM_WAYS,
  parameter int WAY_WIDTH   = icache_pkg::WAY_WIDTH
) (
  input  logic                            clk,
  input  logic                            rd_en_i,
  input  logic                            wr_en_i,
  input  logic [INDEX_WIDTH-1:0]          index_i,
  input  logic [WAY_WIDTH-1:0]            way_i,
  input  logic [icache_pkg::DATA_WIDTH-1:0] wr_data_i,
  output logic [icache_pkg::DATA_WIDTH-1:0] rd_data_o
);

  localparam int NUM_SETS = 1 << INDEX_WIDTH;

  logic [icache_pkg::DATA_WIDTH-1:0] mem_q [NUM_WAYS][NUM_SETS];

  // read register only moves on a command, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[way_i][index_i] <= wr_data_i;
      rd_data_o             <= wr_data_i;  // miss returns the refill word
    end else if (rd_en_i) begin
      rd_data_o <= mem_q[way_i][index_i];
    end
  end

endmodule

/* hdl/icache_tag_store.sv */
// tag and valid arrays with hit compare and per-set round-robin victim pointers
`timescale 1ns/100ps

module icache_tag_store #(
  parameter int INDEX_WIDTH = icache_pkg::INDEX_WIDTH,
  parameter int NUM_WAYS    = icache_pkg::NUM_WAYS,
  parameter int WAY_WIDTH   = icache_pkg::WAY_WIDTH,
  parameter int TAG_WIDTH   = icache_pkg::TAG_WIDTH
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] lookup_addr_i,
  output logic                            hit_o,
  output logic [WAY_WIDTH-1:0]            hit_way_o,
  output logic [WAY_WIDTH-1:0]            victim_way_o,
  input  logic                            alloc_i,
  input  logic [WAY_WIDTH-1:0]            alloc_way_i,
  input  logic                            valid_set_i,
  input  logic                            flush_active_i,
  input  logic [INDEX_WIDTH-1:0]          flush_index_i
);
  import icache_pkg::*;

  localparam int NUM_SETS = 1 << INDEX_WIDTH;

  logic [TAG_WIDTH-1:0]   tag_q   [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0]    valid_q [NUM_SETS];
  logic [WAY_WIDTH-1:0]   ptr_q   [NUM_SETS];  // next victim per set
  logic [INDEX_WIDTH-1:0] lookup_index;
  logic [TAG_WIDTH-1:0]   lookup_tag;
  logic [INDEX_WIDTH-1:0] alloc_index_q;        // set being refilled
  logic [WAY_WIDTH-1:0]   alloc_way_q;
  logic [NUM_WAYS-1:0]    match;

  assign lookup_index = lookup_addr_i[INDEX_LSB +: INDEX_WIDTH];
  assign lookup_tag   = lookup_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_q[lookup_index][w] && (tag_q[w][lookup_index] == lookup_tag);
      if (match[w]) begin
        hit_way_o = WAY_WIDTH'(w);
      end
    end
  end

  assign hit_o        = |match;
  assign victim_way_o = ptr_q[lookup_index];

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      tag_q[alloc_way_i][lookup_index] <= lookup_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        ptr_q[s]   <= '0;
      end
      alloc_index_q <= '0;
      alloc_way_q   <= '0;
    end else if (flush_active_i) begin
      valid_q[flush_index_i] <= '0;  // pointers survive a flush
    end else if (alloc_i) begin
      valid_q[lookup_index][alloc_way_i] <= 1'b0;  // stale until refill lands
      alloc_index_q <= lookup_index;
      alloc_way_q   <= alloc_way_i;
    end else if (valid_set_i) begin
      valid_q[alloc_index_q][alloc_way_q] <= 1'b1;
      ptr_q[alloc_index_q] <= ptr_q[alloc_index_q] + 1'b1;
    end
  end

endmodule

/* hdl/icache_flush_counter.sv */
// set index sweep counter, walks every set once per invalidate request
`timescale 1ns/100ps

module icache_flush_counter #(
  parameter int INDEX_WIDTH = icache_pkg::INDEX_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  output logic [INDEX_WIDTH-1:0] index_o,
  output logic                   done_o
);

  logic                   active_q;
  logic [INDEX_WIDTH-1:0] count_q;

  assign index_o = count_q;
  assign done_o  = active_q && (count_q == '1);  // last set on this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
      count_q  <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      count_q  <= '0;
    end else if (active_q) begin
      count_q <= count_q + 1'b1;  // wraps back to zero after the last set
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

/* hdl/icache_pkg.sv */
// shared widths, address helpers and controller states, imported by every cache module
package icache_pkg;

  localparam int ADDR_WIDTH   = 32;  // physical address
  localparam int DATA_WIDTH   = 64;  // one word per line
  localparam int OFFSET_WIDTH = 3;
  localparam int INDEX_WIDTH  = 6;   // 64 sets
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int NUM_WAYS     = 2;
  localparam int WAY_WIDTH    = 1;

  localparam int INDEX_LSB    = OFFSET_WIDTH;  // index sits right above the byte offset

  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,  // waiting for a fetch or a flush
    S_HIT   = 3'd1,  // returning a word upstream
    S_AR    = 3'd2,  // refill request outstanding
    S_R     = 3'd3,  // waiting for refill data
    S_FLUSH = 3'd4   // valid bits being swept
  } cache_state_e;

  // clears the byte offset so lookup and refill use the word address
  function automatic logic [ADDR_WIDTH-1:0] addr_align(input logic [ADDR_WIDTH-1:0] addr);
    return {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  endfunction

endpackage
